/* common/vec_defines.svh */
// widths, list depth and apb register addresses of the vector engine
`ifndef VEC_DEFINES_SVH
`define VEC_DEFINES_SVH

`define VEC_COORD_W    8                  // one screen coordinate
`define VEC_BRES_W     (`VEC_COORD_W + 1) // signed coords in the drawer
`define VEC_ADR_W      8                  // 256 list words

`define VEC_APB_AW     12
`define VEC_APB_DW     32

`define VEC_REG_CTRL   12'h000
`define VEC_REG_STATUS 12'h004
`define VEC_LIST_BASE  12'h400            // one list word per 4 bytes

`endif

/* common/vec_pkg.sv */
// vector engine types: list word, signed coordinate, segment, pixel and apb structs
`include "vec_defines.svh"

package vec_pkg;

    // one display list entry, x in the top bits as in the list format
    typedef struct packed {
        logic [`VEC_COORD_W-1:0] x;
        logic [`VEC_COORD_W-1:0] y;
        logic                    line;
        logic                    pos;
    } list_word_t;

    typedef logic signed [`VEC_BRES_W-1:0] coord_s_t;

    typedef struct packed {
        coord_s_t stax;
        coord_s_t stay;
        coord_s_t endx;
        coord_s_t endy;
    } segment_t;

    typedef struct packed {
        logic [`VEC_COORD_W-1:0] x;
        logic [`VEC_COORD_W-1:0] y;
        logic                    last; // final pixel of a segment
    } pixel_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`VEC_APB_AW-1:0] paddr;
        logic [`VEC_APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`VEC_APB_DW-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

endpackage

/* draw/line_drawer.sv */
// bresenham line stepper putting out one pixel per accepted cycle
`timescale 1ns/1ps
`include "vec_defines.svh"

module line_drawer (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  vec_pkg::segment_t seg,
    output logic              busy,
    output logic              done,
    output logic              pixel_valid,
    input  logic              pixel_ready,
    output vec_pkg::pixel_t   pixel
);

    localparam int ERR_W = `VEC_BRES_W + 3; // room for twice the error term

    typedef enum logic [1:0] {S_IDLE, S_SETUP, S_RUN, S_DONE} state_t;

    state_t             state;
    vec_pkg::coord_s_t  cur_x, cur_y;
    logic signed [ERR_W-1:0] adx, ady;
    logic signed [ERR_W-1:0] dx, dy, err, e2, err_step;
    logic               sx_neg, sy_neg;
    logic               at_end, step_x, step_y;

    //////////////////////////////////////////////////
    // error term
    //////////////////////////////////////////////////
    assign adx    = (seg.endx >= seg.stax) ? seg.endx - seg.stax : seg.stax - seg.endx;
    assign ady    = (seg.endy >= seg.stay) ? seg.endy - seg.stay : seg.stay - seg.endy;
    assign at_end = (cur_x == seg.endx) && (cur_y == seg.endy);
    assign e2     = err <<< 1;
    assign step_x = e2 >= dy;
    assign step_y = e2 <= dx;

    always_comb begin
        err_step = err;
        if (step_x)
            err_step = err_step + dy;
        if (step_y)
            err_step = err_step + dx;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (start) state <= S_SETUP;
                S_SETUP: state <= S_RUN;
                S_RUN:   if (pixel_ready && at_end) state <= S_DONE;
                S_DONE:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // stepping datapath
    always_ff @(posedge clk) begin
        if (state == S_SETUP) begin
            dx     <= adx;
            dy     <= -ady;          // negative by convention
            err    <= adx - ady;
            sx_neg <= seg.endx < seg.stax;
            sy_neg <= seg.endy < seg.stay;
            cur_x  <= seg.stax;
            cur_y  <= seg.stay;
        end else if (state == S_RUN && pixel_ready && !at_end) begin
            err <= err_step;
            if (step_x)
                cur_x <= sx_neg ? cur_x - 1'b1 : cur_x + 1'b1;
            if (step_y)
                cur_y <= sy_neg ? cur_y - 1'b1 : cur_y + 1'b1;
        end
    end

    assign busy        = state != S_IDLE;
    assign done        = state == S_DONE;  // cycle after last accept
    assign pixel_valid = state == S_RUN;
    assign pixel.x     = cur_x[`VEC_COORD_W-1:0];
    assign pixel.y     = cur_y[`VEC_COORD_W-1:0];
    assign pixel.last  = at_end;

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    pixel_in_box: assert property (@(posedge clk) disable iff (rst)
        pixel_valid |->
            ((cur_x >= seg.stax && cur_x <= seg.endx) ||
             (cur_x <= seg.stax && cur_x >= seg.endx)) &&
            ((cur_y >= seg.stay && cur_y <= seg.endy) ||
             (cur_y <= seg.stay && cur_y >= seg.endy)));

    pixel_hold: assert property (@(posedge clk) disable iff (rst)
        (pixel_valid && !pixel_ready) |=> (pixel_valid && $stable(pixel)));

endmodule

/* draw/vector_sequencer.sv */
// display list sequencer turning list words into line segments and frame ends
`timescale 1ns/1ps
`include "vec_defines.svh"

module vector_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  vec_pkg::list_word_t   rdata,
    output logic [`VEC_ADR_W-1:0] raddr,
    input  logic                  busy,
    input  logic                  done,
    output logic                  start,
    output vec_pkg::segment_t     seg,
    output logic                  frame_end,
    output logic                  running
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_WAIT_DATA,
        S_DECODE,
        S_SEND,
        S_WAIT_DONE,
        S_NEXT_ADDR,
        S_FRAME_END
    } state_t;

    state_t                state, state_nxt;
    logic [`VEC_ADR_W-1:0] addr;
    vec_pkg::coord_s_t     pen_x, pen_y;   // last pen position
    vec_pkg::coord_s_t     word_x, word_y;
    logic                  is_eof;

    assign word_x = {1'b0, rdata.x};       // unsigned to signed
    assign word_y = {1'b0, rdata.y};
    assign is_eof = rdata.pos && rdata.line;

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:      state_nxt = enable ? S_FETCH : S_IDLE;
            S_FETCH:     state_nxt = S_WAIT_DATA;
            S_WAIT_DATA: state_nxt = S_DECODE;
            S_DECODE: begin
                if (is_eof)
                    state_nxt = S_FRAME_END;
                else if (rdata.pos || rdata.line)
                    state_nxt = S_SEND;
                else
                    state_nxt = S_NEXT_ADDR;   // skip word
            end
            S_SEND:      state_nxt = S_WAIT_DONE;
            S_WAIT_DONE: state_nxt = done ? S_NEXT_ADDR : S_WAIT_DONE;
            S_NEXT_ADDR: state_nxt = S_WAIT_DATA; // new address already out
            S_FRAME_END: state_nxt = enable ? S_FETCH : S_IDLE;
            default:     state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            addr  <= '0;
            pen_x <= '0;
            pen_y <= '0;
        end else begin
            state <= state_nxt;
            if (state_nxt == S_NEXT_ADDR)
                addr <= addr + 1'b1;
            if (state == S_DECODE) begin
                if (is_eof) begin
                    addr  <= '0;              // restart the list
                    pen_x <= '0;
                    pen_y <= '0;
                end else if (rdata.pos || rdata.line) begin
                    pen_x <= word_x;
                    pen_y <= word_y;
                end
            end
        end
    end

    // segment ends, held until the drawer is done
    always_ff @(posedge clk) begin
        if (state == S_DECODE && !is_eof) begin
            seg.endx <= word_x;
            seg.endy <= word_y;
            seg.stax <= rdata.pos ? word_x : pen_x; // line starts at the pen
            seg.stay <= rdata.pos ? word_y : pen_y;
        end
    end

    assign raddr     = addr;
    assign start     = state == S_SEND;
    assign frame_end = state == S_FRAME_END;
    assign running   = state != S_IDLE;

    no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

/* filelist.f */
+incdir+common
common/vec_pkg.sv
hw/vec_apb_regs.sv
hw/display_list_ram.sv
draw/vector_sequencer.sv
draw/line_drawer.sv
hw/vector_engine_top.sv
test/vector_engine_tb.sv

/* hw/display_list_ram.sv */
// display list memory with one write port and one registered read port
`timescale 1ns/1ps
`include "vec_defines.svh"

module display_list_ram (
    input  logic                  clk,
    input  logic                  we,
    input  logic [`VEC_ADR_W-1:0] waddr,
    input  logic [`VEC_ADR_W-1:0] raddr,
    input  vec_pkg::list_word_t   wdata,
    output vec_pkg::list_word_t   rdata
);

    localparam int DEPTH = 1 << `VEC_ADR_W;

    vec_pkg::list_word_t mem [0:DEPTH-1];

    // write port, driven from the apb window
    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // read port
    // same address in one cycle gives the old word
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* hw/vec_apb_regs.sv */
// apb slave with ctrl and status registers, list write window and frame counter
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_apb_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  vec_pkg::apb_req_t           apb_req,
    output vec_pkg::apb_rsp_t           apb_rsp,
    output logic                        enable,
    input  logic                        running,
    input  logic                        frame_end,
    output logic                        list_we,
    output logic [`VEC_ADR_W-1:0]       list_waddr,
    output vec_pkg::list_word_t         list_wdata
);

    localparam int LIST_SPAN = 1 << (`VEC_ADR_W + 2); // bytes in the list window

    logic        access;
    logic        ctrl_hit, status_hit, list_hit;
    logic [15:0] frame_cnt;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////
    assign access     = apb_req.psel && apb_req.penable;
    assign ctrl_hit   = apb_req.paddr == `VEC_REG_CTRL;
    assign status_hit = apb_req.paddr == `VEC_REG_STATUS;
    assign list_hit   = (apb_req.paddr >= `VEC_LIST_BASE) &&
                        (apb_req.paddr < (`VEC_LIST_BASE + LIST_SPAN));

    // zero wait states, list window reads back as zero
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !(ctrl_hit || status_hit || list_hit);
        apb_rsp.prdata  = '0;
        if (ctrl_hit)
            apb_rsp.prdata = {31'b0, enable};
        else if (status_hit)
            apb_rsp.prdata = {15'b0, running, frame_cnt};
    end

    assign list_we    = access && apb_req.pwrite && list_hit;
    assign list_waddr = apb_req.paddr[`VEC_ADR_W+1:2]; // word address
    assign list_wdata = apb_req.pwdata[$bits(vec_pkg::list_word_t)-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            enable    <= 1'b0;
            frame_cnt <= '0;
        end else begin
            if (access && apb_req.pwrite && ctrl_hit)
                enable <= apb_req.pwdata[0];
            if (frame_end)
                frame_cnt <= frame_cnt + 1'b1; // wraps at 16 bits
        end
    end

    //////////////////////////////////////////////////
    // protocol checks
    //////////////////////////////////////////////////
    penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel);

    paddr_stable: assert property (@(posedge clk) disable iff (rst)
        (apb_req.psel && !apb_req.penable) |=> $stable(apb_req.paddr));

endmodule

/* hw/vector_engine_top.sv */
// vector engine top with apb registers, list memory, sequencer and line drawer
`timescale 1ns/1ps
`include "vec_defines.svh"

module vector_engine_top (
    input  logic              clk,
    input  logic              rst,
    input  vec_pkg::apb_req_t apb_req,
    output vec_pkg::apb_rsp_t apb_rsp,
    output logic              pixel_valid,
    input  logic              pixel_ready,
    output vec_pkg::pixel_t   pixel,
    output logic              frame_end
);

    logic                  enable, running;
    logic                  list_we;
    logic [`VEC_ADR_W-1:0] list_waddr, list_raddr;
    vec_pkg::list_word_t   list_wdata, list_rdata;
    logic                  start, busy, done;
    vec_pkg::segment_t     seg;

    //////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////
    vec_apb_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .enable     (enable),
        .running    (running),
        .frame_end  (frame_end),
        .list_we    (list_we),
        .list_waddr (list_waddr),
        .list_wdata (list_wdata)
    );

    display_list_ram u_ram (
        .clk   (clk),
        .we    (list_we),
        .waddr (list_waddr),
        .raddr (list_raddr),
        .wdata (list_wdata),
        .rdata (list_rdata)
    );

    //////////////////////////////////////////////////
    // drawing pipeline
    //////////////////////////////////////////////////
    vector_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .rdata     (list_rdata),
        .raddr     (list_raddr),
        .busy      (busy),
        .done      (done),
        .start     (start),
        .seg       (seg),
        .frame_end (frame_end),
        .running   (running)
    );

    line_drawer u_draw (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .seg         (seg),
        .busy        (busy),
        .done        (done),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .pixel       (pixel)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the vector engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module vector_engine_tb \
    --Mdir obj_dir -o vector_engine_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/vector_engine_sim > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* test/vector_engine_tb.sv */
// vector engine testbench with apb driver, reference pixel model, random ready and checks
`timescale 1ns/1ps
`include "vec_defines.svh"

module vector_engine_tb;

    logic                clk;
    logic                rst;
    vec_pkg::apb_req_t   apb_req;
    vec_pkg::apb_rsp_t   apb_rsp;
    logic                pixel_valid;
    logic                pixel_ready;
    vec_pkg::pixel_t     pixel;
    logic                frame_end;

    vec_pkg::list_word_t word_q[$];       // all list words from the file
    int                  grp_first[$];
    int                  grp_len[$];
    int                  grp_cnt[$];      // expected pixels per frame
    vec_pkg::pixel_t     exp_q[$];
    vec_pkg::pixel_t     held_pix;
    logic                hold_pending = 1'b0;
    logic [31:0]         rnd_state = 32'hcb85;
    int                  fe_count = 0;
    int                  pix_in_frame = 0;
    int                  cur_count = 0;
    int                  cycle_cnt = 0;
    int                  cycle_limit = 100000;

    vector_engine_top uut (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .pixel       (pixel),
        .frame_end   (frame_end)
    );

    always #10 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    //////////////////////////////////////////////////
    // bresenham reference model over the list words
    //////////////////////////////////////////////////
    function automatic int model_frame(input int first, input int n, input bit push);
        vec_pkg::list_word_t w;
        vec_pkg::pixel_t     p;
        int px, py, x, y, x1, y1, dx, dy, sx, sy, err, e2, cnt, i;
        bit seg_done;
        px  = 0;
        py  = 0;
        cnt = 0;
        for (i = 0; i < n; i++) begin
            w = word_q[first + i];
            if (w.pos && w.line)
                break;                     // end of frame
            if (w.pos || w.line) begin
                x1 = w.x;
                y1 = w.y;
                x  = w.pos ? x1 : px;      // pos word is a single point
                y  = w.pos ? y1 : py;
                dx = (x1 > x) ? x1 - x : x - x1;
                dy = (y1 > y) ? y - y1 : y1 - y; // kept negative
                sx = (x < x1) ? 1 : -1;
                sy = (y < y1) ? 1 : -1;
                err = dx + dy;
                seg_done = 1'b0;
                while (!seg_done) begin
                    p.x    = x[7:0];
                    p.y    = y[7:0];
                    p.last = (x == x1) && (y == y1);
                    if (push)
                        exp_q.push_back(p);
                    cnt++;
                    if (p.last) begin
                        seg_done = 1'b1;
                    end else begin
                        e2 = 2 * err;
                        if (e2 >= dy) begin
                            err = err + dy;
                            x   = x + sx;
                        end
                        if (e2 <= dx) begin
                            err = err + dx;
                            y   = y + sy;
                        end
                    end
                end
                px = x1;
                py = y1;
            end
        end
        return cnt;
    endfunction

    //////////////////////////////////////////////////
    // apb host
    //////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic slverr);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        assert (apb_rsp.pready) else stop_on_error("ERROR pready exp 1 got 0");
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic check_status(input logic [31:0] exp);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b0, `VEC_REG_STATUS, 32'h0, rdata, slverr);
        assert (rdata == exp && !slverr)
            else stop_on_error($sformatf("ERROR prdata exp %h got %h", exp, rdata));
    endtask

    // load one group, draw it twice and stop at the second frame end
    task automatic run_group(input int g);
        logic [31:0] rdata;
        logic        slverr;
        int          i;
        int          n_model;
        int          fe_start;
        for (i = 0; i < grp_len[g]; i++) begin
            apb_access(1'b1, 12'(`VEC_LIST_BASE + 4 * i),
                       32'(word_q[grp_first[g] + i]), rdata, slverr);
            assert (!slverr) else stop_on_error("ERROR pslverr exp 0 got 1");
        end
        n_model = model_frame(grp_first[g], grp_len[g], 1'b1);
        void'(model_frame(grp_first[g], grp_len[g], 1'b1));
        assert (n_model == grp_cnt[g])
            else stop_on_error($sformatf("ERROR model count exp %h got %h", grp_cnt[g], n_model));
        cur_count = grp_cnt[g];
        fe_start  = fe_count;
        apb_access(1'b1, `VEC_REG_CTRL, 32'h1, rdata, slverr);
        wait (fe_count == fe_start + 1);
        apb_access(1'b1, `VEC_REG_CTRL, 32'h0, rdata, slverr);
        wait (fe_count == fe_start + 2);
        repeat (30) @(posedge clk);       // engine must stay quiet now
        assert (exp_q.size() == 0)
            else stop_on_error($sformatf("ERROR exp_q size exp %h got %h", 0, exp_q.size()));
        assert (fe_count == fe_start + 2)
            else stop_on_error($sformatf("ERROR frame_end count exp %h got %h",
                                         fe_start + 2, fe_count));
        check_status({16'h0, fe_count[15:0]});
    endtask

    //////////////////////////////////////////////////
    // ready driver, pixel monitor and timeout
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        rnd_state   = xorshift32(rnd_state);
        pixel_ready = rnd_state[1:0] != 2'b00;  // about 3 in 4 cycles
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (hold_pending) begin
                assert (pixel_valid && pixel == held_pix)
                    else stop_on_error($sformatf("ERROR pixel held exp %h got %h",
                                                 held_pix, pixel));
            end
            hold_pending = pixel_valid && !pixel_ready;
            held_pix     = pixel;
            if (pixel_valid && pixel_ready) begin
                assert (exp_q.size() > 0)
                    else stop_on_error("a pixel was accepted while none was expected");
                assert (pixel == exp_q[0])
                    else stop_on_error($sformatf("ERROR pixel exp %h got %h", exp_q[0], pixel));
                void'(exp_q.pop_front());
                pix_in_frame++;
            end
            if (frame_end) begin
                assert (pix_in_frame == cur_count)
                    else stop_on_error($sformatf("ERROR frame pixel count exp %h got %h",
                                                 cur_count, pix_in_frame));
                fe_count++;
                pix_in_frame = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit)
            stop_on_error($sformatf("timeout after %0d cycles, tests did not finish", cycle_cnt));
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        int          fd;
        int          g;
        int          i;
        int          first;
        int          total;
        string       line;
        byte         tag;
        logic [31:0] val;
        logic [31:0] rdata;
        logic        slverr;
        clk         = 1'b0;
        rst         = 1'b1;
        apb_req     = '0;
        pixel_ready = 1'b0;
        first       = 0;
        total       = 0;
        fd = $fopen("test/vector_stimulus.txt", "r");
        assert (fd != 0) else stop_on_error("the stimulus file could not be opened");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%c %h", tag, val) == 2 && tag != "#") begin
                if (tag == "w") begin
                    word_q.push_back(val[17:0]);
                end else if (tag == "c") begin
                    grp_first.push_back(first);
                    grp_len.push_back(word_q.size() - first);
                    grp_cnt.push_back(val);
                    total = total + 2 * int'(val);  // each group is drawn twice
                    first = word_q.size();
                end
            end
        end
        $fclose(fd);
        assert (grp_cnt.size() > 0) else stop_on_error("the stimulus file holds no test group");
        cycle_limit = 40 * total + 2000;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle engine after reset
        for (i = 0; i < 50; i++) begin
            @(posedge clk);
            assert (!pixel_valid) else stop_on_error("ERROR pixel_valid exp 0 got 1");
        end
        assert (fe_count == 0)
            else stop_on_error($sformatf("ERROR frame_end count exp %h got %h", 0, fe_count));
        check_status(32'h0);

        // undecoded addresses
        apb_access(1'b0, 12'h100, 32'h0, rdata, slverr);
        assert (slverr) else stop_on_error("ERROR pslverr exp 1 got 0");
        apb_access(1'b1, 12'h800, 32'h1, rdata, slverr);
        assert (slverr) else stop_on_error("ERROR pslverr exp 1 got 0");

        for (g = 0; g < grp_cnt.size(); g++)
            run_group(g);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* test/vector_stimulus.txt */
# w: list word in hex, x[17:10] y[9:2] line[1] pos[0]
# c: expected pixel count of the frame in hex, closes a group
# single points with a skip word
w 02851
w 0CD10
w 32015
w 00001
w 00003
c 3
# closed path through all eight octants, a diagonal and a zero length line
w 19191
w 1B99E
w 1C5C6
w 1B9EE
w 191FA
w 169EE
w 15DC6
w 1699E
w 19192
w 1E1E2
w 1E1E2
w 00003
c 6F
# screen edges
w 00001
w 3FC02
w 3FFFE
w 00003
c 201
